/* dv/mgmt_rx_buffer_tb.sv */
`timescale 1ns/1ps

module mgmt_rx_buffer_tb;

	localparam int DATA_DEPTH = 1024;
	localparam int HDR_DEPTH = 4;
	// Frame limits as seen from the MAC side
	localparam int MAX_BYTES = 1500;
	localparam int ADMIT_WORDS = 375;
	// Cycles to wait for a length entry
	localparam int WAIT_LIMIT = 50;

	logic eth_rx_clk;
	logic arst_n;
	logic rx_start;
	logic rx_data_valid;
	logic [31:0] rx_data;
	logic [2:0] rx_bytes_valid;
	logic rx_commit;
	logic rx_drop;
	logic link_up;
	logic data_pop;
	logic len_pop;
	logic [31:0] data_rd;
	logic [10:0] data_count;
	logic [10:0] len_rd;
	logic len_empty;

	// Model of accepted frames still in the buffer
	int exp_len_q[$];
	logic [31:0] exp_word_q[$];
	int seed;
	int errors;
	int frames_sent;
	event abort_ev;

	mgmt_rx_buffer #(
		.DATA_DEPTH(DATA_DEPTH),
		.HDR_DEPTH(HDR_DEPTH)
	) uut (.*);

	initial begin
		eth_rx_clk = 1'b0;
		forever #2 eth_rx_clk = ~eth_rx_clk;
	end

	task automatic report_mismatch(input string msg);
		errors++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	// Link loss empties both FIFOs by the next cycle
	assert property (@(posedge eth_rx_clk) disable iff (!arst_n)
		($past(!link_up) && $past(link_up, 2)) |-> (len_empty && data_count == '0))
		else report_mismatch("FIFOs not empty one cycle after link loss");

	// A dropped frame leaves no length entry behind
	assert property (@(posedge eth_rx_clk) disable iff (!arst_n)
		$past(rx_drop && len_empty, 2) |-> len_empty)
		else report_mismatch("length entry appeared after a dropped frame");

	// Timeout ends the run through the main process
	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		errors++;
		-> abort_ev;
		@(negedge eth_rx_clk);
	endtask

	function automatic int rand_len(input int max_len);
		return 1 + int'($unsigned($random(seed)) % max_len);
	endfunction

	task automatic send_frame(input int nbytes, input bit end_with_drop);
		int nwords;
		int sum_bytes;
		int bytes;
		int prev_count;
		int exp_count;
		bit accept;
		logic [31:0] word;
		nwords = (nbytes + 3) / 4;
		sum_bytes = 0;
		// Refused at start, or discarded on length or drop
		accept = !end_with_drop && (nbytes <= MAX_BYTES) && (exp_len_q.size() < HDR_DEPTH)
			&& ((DATA_DEPTH - exp_word_q.size()) >= ADMIT_WORDS);
		// Stored word count before this frame, from the model
		prev_count = exp_word_q.size();
		frames_sent++;
		rx_start = 1'b1;
		@(negedge eth_rx_clk);
		rx_start = 1'b0;
		for (int i = 0; i < nwords; i++) begin
			word = $random(seed);
			// Only the last word may be short
			bytes = (i == nwords - 1) ? nbytes - 4 * i : 4;
			sum_bytes += bytes;
			rx_data_valid = 1'b1;
			rx_data = word;
			rx_bytes_valid = 3'(bytes);
			if (accept) begin
				exp_word_q.push_back(word);
			end
			@(negedge eth_rx_clk);
		end
		rx_data_valid = 1'b0;
		@(negedge eth_rx_clk);
		rx_commit = !end_with_drop;
		rx_drop = end_with_drop;
		@(negedge eth_rx_clk);
		rx_commit = 1'b0;
		rx_drop = 1'b0;
		@(negedge eth_rx_clk);
		// Two cycles after the commit strobe
		if (accept) begin
			exp_len_q.push_back(sum_bytes);
		end
		exp_count = prev_count + (accept ? nwords : 0);
		assert (int'(data_count) == exp_count)
			else report_mismatch($sformatf("data_count %0d, expected %0d", data_count, exp_count));
		assert (len_empty == (exp_len_q.size() == 0))
			else report_mismatch($sformatf("len_empty %0b after frame of %0d bytes",
				len_empty, nbytes));
	endtask

	task automatic drain_frame();
		int waited;
		int exp_len;
		int nwords;
		logic [31:0] exp_word;
		waited = 0;
		while (len_empty && waited < WAIT_LIMIT) begin
			@(negedge eth_rx_clk);
			waited++;
		end
		if (len_empty) begin
			stop_on_timeout("a frame length entry");
		end
		exp_len = (exp_len_q.size() != 0) ? exp_len_q.pop_front() : 0;
		assert (int'(len_rd) == exp_len)
			else report_mismatch($sformatf("length %0d, expected %0d", len_rd, exp_len));
		len_pop = 1'b1;
		@(negedge eth_rx_clk);
		len_pop = 1'b0;
		nwords = (exp_len + 3) / 4;
		// Head word falls through, one pop per cycle
		for (int i = 0; i < nwords; i++) begin
			exp_word = exp_word_q.pop_front();
			assert (data_rd == exp_word)
				else report_mismatch($sformatf("word %0d read %h, expected %h",
					i, data_rd, exp_word));
			data_pop = 1'b1;
			@(negedge eth_rx_clk);
		end
		data_pop = 1'b0;
	endtask

	task automatic check_empty(input string where);
		assert (len_empty && data_count == '0)
			else report_mismatch($sformatf("buffer not empty %s", where));
	endtask

	task automatic run_all();
		repeat (16) @(negedge eth_rx_clk);
		arst_n = 1'b1;
		@(negedge eth_rx_clk);
		check_empty("after reset");
		assert (!uut.u_push.wr_en && !uut.u_push.commit && !uut.u_push.rollback
			&& !uut.u_push.len_wr)
			else report_mismatch("push strobes active after reset");
		// Random length frames, written and read back
		repeat (4) begin
			send_frame(rand_len(MAX_BYTES), 1'b0);
			drain_frame();
		end
		// Dropped by the MAC, then a good one
		send_frame(rand_len(400), 1'b1);
		send_frame(rand_len(MAX_BYTES), 1'b0);
		drain_frame();
		// Oversize frames, just over and well over
		send_frame(1501, 1'b0);
		send_frame(1600, 1'b0);
		send_frame(rand_len(MAX_BYTES), 1'b0);
		drain_frame();
		// Fifth frame finds the length FIFO full
		repeat (5) begin
			send_frame(rand_len(200), 1'b0);
		end
		repeat (4) begin
			drain_frame();
		end
		@(negedge eth_rx_clk);
		check_empty("after draining four frames");
		send_frame(rand_len(MAX_BYTES), 1'b0);
		drain_frame();
		// Link loss with frames stored
		send_frame(rand_len(300), 1'b0);
		send_frame(rand_len(300), 1'b0);
		link_up = 1'b0;
		@(negedge eth_rx_clk);
		link_up = 1'b1;
		check_empty("one cycle after link loss");
		exp_len_q.delete();
		exp_word_q.delete();
		@(negedge eth_rx_clk);
		send_frame(rand_len(MAX_BYTES), 1'b0);
		drain_frame();
		repeat (4) @(negedge eth_rx_clk);
	endtask

	task automatic end_run();
		$display("Summary: %0d frames sent, %0d errors", frames_sent, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	initial begin
		seed = 65;
		errors = 0;
		frames_sent = 0;
		arst_n = 1'b0;
		rx_start = 1'b0;
		rx_data_valid = 1'b0;
		rx_data = '0;
		rx_bytes_valid = '0;
		rx_commit = 1'b0;
		rx_drop = 1'b0;
		link_up = 1'b1;
		data_pop = 1'b0;
		len_pop = 1'b0;
		fork
			run_all();
			@(abort_ev);
		join_any
		end_run();
	end

endmodule

/* hw/eth_rx_pkg.sv */
// Constants describing the receive stream coming out of the management MAC
// Everything here is about the wire format and the Ethernet framing limits
package eth_rx_pkg;

	// One stream word carries up to four bytes
	localparam int rx_data_width = 32;

	// Count of valid bytes in a word, 1 to 4
	// Only the last word of a frame may be short
	localparam int rx_bytes_width = 3;

	// Largest frame accepted into the buffer, in bytes
	// Anything longer is discarded while it is still arriving
	localparam int max_frame_bytes = 1500;

	// Width of a frame length record
	// 11 bits reach 2047, enough for max_frame_bytes plus one extra word
	localparam int frame_len_width = 11;

endpackage

/* hw/frame_len_fifo.sv */
`timescale 1ns/1ps

// Small fall-through FIFO holding one length per committed frame
module frame_len_fifo #(
	parameter int DEPTH = 32
) (
	input logic eth_rx_clk,
	input logic arst_n,
	input logic flush,
	input logic wr,
	input logic [eth_rx_pkg::frame_len_width-1:0] wdata,
	input logic pop,
	output logic full,
	output logic empty,
	output logic [eth_rx_pkg::frame_len_width-1:0] rd_data
);
	import eth_rx_pkg::*;

	localparam int ADDR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(DEPTH);
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

	logic [frame_len_width-1:0] mem [DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	always_ff @(posedge eth_rx_clk) begin
		if (wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Oldest length is always on the output
	assign rd_data = mem[rd_ptr];
	assign full = (count == DEPTH_CNT);
	assign empty = (count == '0);

	always_ff @(posedge eth_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(wr) - CNT_W'(pop);
		end
	end

	// Admission at frame start is what keeps this from happening
	assert property (@(posedge eth_rx_clk) disable iff (!arst_n) wr |-> !full)
		else $error("frame_len_fifo: write while full");

	assert property (@(posedge eth_rx_clk) disable iff (!arst_n) pop |-> !empty)
		else $error("frame_len_fifo: pop while empty");

endmodule

/* hw/mgmt_rx_buffer.sv */
`timescale 1ns/1ps

// Receive frame buffer for the management Ethernet port
// Push FSM feeding a packet FIFO and a frame length FIFO
module mgmt_rx_buffer #(
	parameter int DATA_DEPTH = 1024,
	parameter int HDR_DEPTH = 32
) (
	input logic eth_rx_clk,
	input logic arst_n,
	input logic rx_start,
	input logic rx_data_valid,
	input logic [eth_rx_pkg::rx_data_width-1:0] rx_data,
	input logic [eth_rx_pkg::rx_bytes_width-1:0] rx_bytes_valid,
	input logic rx_commit,
	input logic rx_drop,
	input logic link_up,
	input logic data_pop,
	input logic len_pop,
	output logic [eth_rx_pkg::rx_data_width-1:0] data_rd,
	output logic [$clog2(DATA_DEPTH+1)-1:0] data_count,
	output logic [eth_rx_pkg::frame_len_width-1:0] len_rd,
	output logic len_empty
);
	import eth_rx_pkg::*;

	// Link down empties both FIFOs and parks the push FSM
	logic flush;
	logic wr_en;
	logic [rx_data_width-1:0] wr_data;
	logic commit;
	logic rollback;
	logic [$clog2(DATA_DEPTH+1)-1:0] wr_free;
	logic len_wr;
	logic [frame_len_width-1:0] len_wdata;
	logic len_full;

	assign flush = !link_up;

	mgmt_rx_push #(
		.DATA_DEPTH(DATA_DEPTH)
	) u_push (
		.eth_rx_clk(eth_rx_clk),
		.arst_n(arst_n),
		.flush(flush),
		.rx_start(rx_start),
		.rx_data_valid(rx_data_valid),
		.rx_data(rx_data),
		.rx_bytes_valid(rx_bytes_valid),
		.rx_commit(rx_commit),
		.rx_drop(rx_drop),
		.wr_free(wr_free),
		.len_full(len_full),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.commit(commit),
		.rollback(rollback),
		.len_wr(len_wr),
		.len_wdata(len_wdata)
	);

	packet_fifo #(
		.DEPTH(DATA_DEPTH)
	) u_data_fifo (
		.eth_rx_clk(eth_rx_clk),
		.arst_n(arst_n),
		.flush(flush),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.commit(commit),
		.rollback(rollback),
		.pop(data_pop),
		.wr_free(wr_free),
		.rd_data(data_rd),
		.rd_count(data_count)
	);

	frame_len_fifo #(
		.DEPTH(HDR_DEPTH)
	) u_len_fifo (
		.eth_rx_clk(eth_rx_clk),
		.arst_n(arst_n),
		.flush(flush),
		.wr(len_wr),
		.wdata(len_wdata),
		.pop(len_pop),
		.full(len_full),
		.empty(len_empty),
		.rd_data(len_rd)
	);

endmodule

/* hw/mgmt_rx_push.sv */
`timescale 1ns/1ps

// Push FSM, turns the MAC receive stream into packet FIFO writes
// Also decides admission and records the length of each good frame
module mgmt_rx_push #(
	parameter int DATA_DEPTH = 1024
) (
	input logic eth_rx_clk,
	input logic arst_n,
	input logic flush,
	input logic rx_start,
	input logic rx_data_valid,
	input logic [eth_rx_pkg::rx_data_width-1:0] rx_data,
	input logic [eth_rx_pkg::rx_bytes_width-1:0] rx_bytes_valid,
	input logic rx_commit,
	input logic rx_drop,
	input logic [$clog2(DATA_DEPTH+1)-1:0] wr_free,
	input logic len_full,
	output logic wr_en,
	output logic [eth_rx_pkg::rx_data_width-1:0] wr_data,
	output logic commit,
	output logic rollback,
	output logic len_wr,
	output logic [eth_rx_pkg::frame_len_width-1:0] len_wdata
);
	import eth_rx_pkg::*;
	import rx_buffer_pkg::*;

	localparam int FREE_W = $clog2(DATA_DEPTH + 1);
	localparam logic [FREE_W-1:0] ADMIT_FREE = FREE_W'(min_free_words);
	localparam logic [FREE_W-1:0] LOW_FREE = FREE_W'(2);
	localparam logic [frame_len_width-1:0] MAX_LEN = frame_len_width'(max_frame_bytes);

	push_state_t state;
	logic [frame_len_width-1:0] byte_count;
	logic admit;
	logic abort;

	// Room for a full sized frame and a free length slot
	assign admit = (wr_free >= ADMIT_FREE) && !len_full;

	// Out of space, too long, or the MAC gave up on it
	// wr_free below 2 leaves room for the word already in flight
	assign abort = (wr_free < LOW_FREE) || (byte_count > MAX_LEN) || rx_drop;

	always_ff @(posedge eth_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			byte_count <= '0;
			wr_en <= 1'b0;
			commit <= 1'b0;
			rollback <= 1'b0;
			len_wr <= 1'b0;
		end else begin
			// Strobes are single cycle by default
			wr_en <= 1'b0;
			commit <= 1'b0;
			rollback <= 1'b0;
			len_wr <= 1'b0;

			if (flush) begin
				state <= st_idle;
				byte_count <= '0;
			end else if (rx_start) begin
				// A frame that never ended is thrown away
				rollback <= (state == st_receiving);
				byte_count <= '0;
				state <= admit ? st_receiving : st_dropping;
			end else begin
				case (state)
					st_receiving: begin
						if (abort) begin
							rollback <= 1'b1;
							state <= st_dropping;
						end else if (rx_commit) begin
							// Empty frames leave no trace
							commit <= (byte_count != '0);
							len_wr <= (byte_count != '0);
							state <= st_idle;
						end else if (rx_data_valid) begin
							wr_en <= 1'b1;
							byte_count <= byte_count + frame_len_width'(rx_bytes_valid);
						end
					end
					st_dropping: begin
						// Rollback already done, just wait for the end
						if (rx_commit || rx_drop) begin
							state <= st_idle;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Payload registers
	always_ff @(posedge eth_rx_clk) begin
		if (rx_data_valid) begin
			wr_data <= rx_data;
		end
		if (rx_commit) begin
			len_wdata <= byte_count;
		end
	end

	// MAC ends each frame with exactly one of commit or drop
	assert property (@(posedge eth_rx_clk) disable iff (!arst_n) !(rx_commit && rx_drop))
		else $error("mgmt_rx_push: commit and drop strobes together");

endmodule

/* hw/packet_fifo.sv */
`timescale 1ns/1ps

// Word FIFO with commit / rollback on the write side
// Writes go in tentatively and only become readable after a commit
module packet_fifo #(
	parameter int DEPTH = 1024
) (
	input logic eth_rx_clk,
	input logic arst_n,
	input logic flush,
	input logic wr_en,
	input logic [eth_rx_pkg::rx_data_width-1:0] wr_data,
	input logic commit,
	input logic rollback,
	input logic pop,
	output logic [$clog2(DEPTH+1)-1:0] wr_free,
	output logic [eth_rx_pkg::rx_data_width-1:0] rd_data,
	output logic [$clog2(DEPTH+1)-1:0] rd_count
);
	import eth_rx_pkg::*;

	localparam int ADDR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(DEPTH);
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

	// Storage, no reset needed on payload
	logic [rx_data_width-1:0] mem [DEPTH];

	// Tentative write pointer, moves on every write
	logic [ADDR_W-1:0] wr_ptr;
	// Committed write pointer, end of readable data
	logic [ADDR_W-1:0] comm_ptr;
	logic [ADDR_W-1:0] rd_ptr;

	// Words written since the last commit or rollback
	logic [CNT_W-1:0] pend_count;

	// Pointer wrap, DEPTH need not be a power of two
	function automatic logic [ADDR_W-1:0] next_addr(input logic [ADDR_W-1:0] addr);
		if (addr == LAST_ADDR) begin
			return '0;
		end
		return addr + 1'b1;
	endfunction

	always_ff @(posedge eth_rx_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Head word falls through, no read latency
	assign rd_data = mem[rd_ptr];

	// Free space counts tentative words as used
	assign wr_free = DEPTH_CNT - rd_count - pend_count;

	always_ff @(posedge eth_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			comm_ptr <= '0;
			rd_ptr <= '0;
			pend_count <= '0;
			rd_count <= '0;
		end else if (flush) begin
			// Link loss empties everything, committed or not
			wr_ptr <= '0;
			comm_ptr <= '0;
			rd_ptr <= '0;
			pend_count <= '0;
			rd_count <= '0;
		end else begin
			if (rollback) begin
				// Forget the partial frame, a write in this cycle is lost too
				wr_ptr <= comm_ptr;
				pend_count <= '0;
			end else begin
				if (commit) begin
					comm_ptr <= wr_ptr;
				end
				if (wr_en) begin
					wr_ptr <= next_addr(wr_ptr);
				end
				// A write landing with the commit stays pending
				pend_count <= (commit ? '0 : pend_count) + CNT_W'(wr_en);
			end

			if (pop) begin
				rd_ptr <= next_addr(rd_ptr);
			end

			// Committed words become readable the cycle after commit
			rd_count <= rd_count + ((commit && !rollback) ? pend_count : '0) - CNT_W'(pop);
		end
	end

	// Push side must stop before the tentative pointer laps the reader
	assert property (@(posedge eth_rx_clk) disable iff (!arst_n)
		wr_en |-> (wr_free != '0))
		else $error("packet_fifo: write with no free space");

	// Reader may only pop committed words
	assert property (@(posedge eth_rx_clk) disable iff (!arst_n)
		pop |-> (rd_count != '0))
		else $error("packet_fifo: pop with no committed data");

endmodule

/* hw/rx_buffer_pkg.sv */
// Definitions for the buffer side of the receive path
// Push FSM states and the admission threshold
package rx_buffer_pkg;

	// Push FSM states
	//   st_idle       waiting for a frame start
	//   st_receiving  frame admitted, words go to the packet FIFO
	//   st_dropping   frame refused or aborted, ignore until it ends
	typedef enum logic [1:0] {
		st_idle,
		st_receiving,
		st_dropping
	} push_state_t;

	// Free words needed before a new frame is admitted
	// A full sized frame is max_frame_bytes / 4 words
	localparam int min_free_words = eth_rx_pkg::max_frame_bytes / 4;

endpackage

/* mgmt_rx_buffer.f */
hw/eth_rx_pkg.sv
hw/rx_buffer_pkg.sv
hw/packet_fifo.sv
hw/frame_len_fifo.sv
hw/mgmt_rx_push.sv
hw/mgmt_rx_buffer.sv
dv/mgmt_rx_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the receive buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mgmt_rx_buffer_tb \
	-f mgmt_rx_buffer.f -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"
